// ==== logic/cache_geom_pkg.sv ====
package cache_geom_pkg;

    ////////////////////////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////////////////////////

    // Direct mapped with one line per set
    localparam int line_bytes  = 16;
    localparam int cache_bytes = 32768;
    localparam int set_count   = cache_bytes / line_bytes;

    // Address split of a 32-bit byte address
    localparam int index_bits  = $clog2(set_count);
    localparam int offset_bits = $clog2(line_bytes);
    localparam int tag_bits    = 32 - index_bits - offset_bits;

    ////////////////////////////////////////////////////////////
    // Address and line fields
    ////////////////////////////////////////////////////////////

    typedef logic [index_bits-1:0]   set_index_t;
    typedef logic [tag_bits-1:0]     line_tag_t;
    typedef logic [line_bytes*8-1:0] line_data_t;

    // One word of the set RAM
    typedef struct packed {
        logic       valid;
        line_tag_t  tag;
        line_data_t data;
    } set_line_t;

endpackage

// ==== logic/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Search sequencing
    ////////////////////////////////////////////////////////////

    // Recent store probe before the set RAM path
    typedef enum logic [2:0] {
        idle,
        probe,
        ram_addr,
        ram_wait,
        ram_check
    } lookup_state_t;

    // Width shared by the hit and fill counters
    typedef logic [15:0] hit_count_t;

    ////////////////////////////////////////////////////////////
    // Stage to stage bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        cache_geom_pkg::line_tag_t  tag;
        cache_geom_pkg::set_index_t index;
    } lookup_req_t;

    // Registered answer of the recent store
    typedef struct packed {
        logic                       hit;
        cache_geom_pkg::line_data_t data;
    } probe_result_t;

    // Insert a found line, or drop every entry of one set
    typedef struct packed {
        logic                       fill;
        logic                       invalidate;
        lookup_req_t                req;
        cache_geom_pkg::line_data_t data;
    } recent_fill_t;

endpackage

// ==== logic/recent_line_store.sv ====
`timescale 1ns/10ps

module recent_line_store #(
    parameter int recent_entries = 16
) (
    input  logic                          clk2,
    input  logic                          reset,
    input  cache_ctrl_pkg::lookup_req_t   probe,
    input  logic                          probe_en,
    input  cache_ctrl_pkg::recent_fill_t  cmd,
    output cache_ctrl_pkg::probe_result_t result
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int ptr_bits = $clog2(recent_entries);

    // Entry contents
    lookup_req_t                 entry_req [recent_entries];
    line_data_t                  entry_data [recent_entries];
    logic [recent_entries-1:0]   entry_valid;

    // Round-robin victim
    logic [ptr_bits-1:0]         fill_ptr;

    logic [recent_entries-1:0]   match;
    logic                        match_any;
    line_data_t                  match_data;

    ////////////////////////////////////////////////////////////
    // Parallel compare
    ////////////////////////////////////////////////////////////

    // At most one entry per tag and set, so an OR of the data is enough
    always_comb
    begin
        match_data = '0;
        for (int i = 0; i < recent_entries; i++)
        begin
            match[i] = entry_valid[i] && (entry_req[i] == probe);
            if (match[i])
            begin
                match_data = match_data | entry_data[i];
            end
        end
    end

    assign match_any = |match;

    always_ff @(posedge clk2)
    begin
        if (reset)
        begin
            result.hit <= 1'b0;
        end
        else
        begin
            result.hit <= probe_en && match_any;
        end
    end

    always_ff @(posedge clk2)
    begin
        if (probe_en)
        begin
            result.data <= match_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Fill and invalidate
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk2)
    begin
        if (reset)
        begin
            entry_valid <= '0;
            fill_ptr    <= '0;
        end
        else
        begin
            // A write to the set RAM makes older copies of that set stale
            if (cmd.invalidate)
            begin
                for (int i = 0; i < recent_entries; i++)
                begin
                    if (entry_req[i].index == cmd.req.index)
                    begin
                        entry_valid[i] <= 1'b0;
                    end
                end
            end
            if (cmd.fill)
            begin
                entry_valid[fill_ptr] <= 1'b1;
                fill_ptr              <= fill_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk2)
    begin
        if (cmd.fill)
        begin
            entry_req[fill_ptr]  <= cmd.req;
            entry_data[fill_ptr] <= cmd.data;
        end
    end

endmodule

// ==== logic/set_ram.sv ====
`timescale 1ns/10ps

module set_ram (
    input  logic                       clk2,
    input  cache_geom_pkg::set_index_t addr,
    input  logic                       write_en,
    input  cache_geom_pkg::set_line_t  write_word,
    output cache_geom_pkg::set_line_t  read_word
);
    import cache_geom_pkg::*;

    // One word per set
    set_line_t mem [set_count];

    ////////////////////////////////////////////////////////////
    // Single port with read before write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk2)
    begin
        if (write_en)
        begin
            mem[addr] <= write_word;
        end
        read_word <= mem[addr];
    end

endmodule

// ==== logic/lookup_control.sv ====
`timescale 1ns/10ps

module lookup_control (
    input  logic                          clk2,
    input  logic                          reset,
    input  logic                          lookup,
    input  logic                          fill,
    input  cache_ctrl_pkg::lookup_req_t   req,
    input  cache_geom_pkg::line_data_t    block,
    input  cache_ctrl_pkg::probe_result_t result,
    input  cache_geom_pkg::set_line_t     read_word,
    output logic                          probe_en,
    output cache_ctrl_pkg::recent_fill_t  cmd,
    output cache_geom_pkg::set_index_t    addr,
    output logic                          write_en,
    output cache_geom_pkg::set_line_t     write_word,
    output logic                          lookup_done,
    output logic                          found_in_cache,
    output logic                          updated,
    output cache_geom_pkg::line_data_t    hit_block,
    output cache_ctrl_pkg::hit_count_t    hit_count,
    output cache_ctrl_pkg::hit_count_t    fill_count
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    lookup_state_t state;
    lookup_state_t next_state;
    lookup_req_t   cur_req;
    set_index_t    fill_index;
    logic          recent_hit;
    logic          word_hit;
    logic          ram_hit;

    ////////////////////////////////////////////////////////////
    // Search FSM
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        next_state = state;
        case (state)
            idle:
            begin
                if (lookup)
                begin
                    next_state = probe;
                end
            end
            probe:     next_state = ram_addr;
            ram_addr:  next_state = result.hit ? idle : ram_wait;
            ram_wait:  next_state = ram_check;
            ram_check: next_state = idle;
            default:   next_state = idle;
        endcase
    end

    always_ff @(posedge clk2)
    begin
        if (reset)
        begin
            state <= idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    // Request is held for the whole search
    always_ff @(posedge clk2)
    begin
        if (state == idle && lookup)
        begin
            cur_req <= req;
        end
    end

    ////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////

    assign probe_en   = (state == probe);
    assign recent_hit = (state == ram_addr) && result.hit;
    assign word_hit   = read_word.valid && (read_word.tag == cur_req.tag);
    assign ram_hit    = (state == ram_check) && word_hit;

    assign lookup_done    = recent_hit || (state == ram_check);
    assign found_in_cache = recent_hit || ram_hit;

    always_comb
    begin
        hit_block = '0;
        if (recent_hit)
        begin
            hit_block = result.data;
        end
        else if (ram_hit)
        begin
            hit_block = read_word.data;
        end
    end

    // Doubles as the probe request outside the invalidate cycle
    assign cmd.fill       = ram_hit;
    assign cmd.invalidate = updated;
    assign cmd.req.tag    = cur_req.tag;
    assign cmd.req.index  = updated ? fill_index : cur_req.index;
    assign cmd.data       = read_word.data;

    ////////////////////////////////////////////////////////////
    // Set RAM port with fill priority
    ////////////////////////////////////////////////////////////

    // Address held between reads so read_word stays on the searched set
    assign addr             = fill ? req.index : cur_req.index;
    assign write_en         = fill;
    assign write_word.valid = 1'b1;
    assign write_word.tag   = req.tag;
    assign write_word.data  = block;

    always_ff @(posedge clk2)
    begin
        if (fill)
        begin
            fill_index <= req.index;
        end
    end

    always_ff @(posedge clk2)
    begin
        if (reset)
        begin
            updated    <= 1'b0;
            hit_count  <= '0;
            fill_count <= '0;
        end
        else
        begin
            updated <= fill;
            if (lookup_done && found_in_cache)
            begin
                hit_count <= hit_count + 1'b1;
            end
            if (updated)
            begin
                fill_count <= fill_count + 1'b1;
            end
        end
    end

endmodule

// ==== logic/cache_lookup_top.sv ====
`timescale 1ns/10ps

module cache_lookup_top #(
    parameter int recent_entries = 16
) (
    input  logic                       clk2,
    input  logic                       reset,
    input  logic                       lookup,
    input  logic                       fill,
    input  cache_geom_pkg::line_tag_t  tag,
    input  cache_geom_pkg::set_index_t index,
    input  cache_geom_pkg::line_data_t block,
    output logic                       lookup_done,
    output logic                       found_in_cache,
    output logic                       updated,
    output cache_geom_pkg::line_data_t hit_block,
    output cache_ctrl_pkg::hit_count_t hit_count,
    output cache_ctrl_pkg::hit_count_t fill_count
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    lookup_req_t   req;
    probe_result_t probe_result;
    recent_fill_t  recent_cmd;
    logic          probe_en;
    set_index_t    ram_index;
    logic          ram_write_en;
    set_line_t     ram_write_word;
    set_line_t     ram_read_word;

    assign req.tag   = tag;
    assign req.index = index;

    lookup_control u_control (
        .clk2           (clk2),
        .reset          (reset),
        .lookup         (lookup),
        .fill           (fill),
        .req            (req),
        .block          (block),
        .result         (probe_result),
        .read_word      (ram_read_word),
        .probe_en       (probe_en),
        .cmd            (recent_cmd),
        .addr           (ram_index),
        .write_en       (ram_write_en),
        .write_word     (ram_write_word),
        .lookup_done    (lookup_done),
        .found_in_cache (found_in_cache),
        .updated        (updated),
        .hit_block      (hit_block),
        .hit_count      (hit_count),
        .fill_count     (fill_count)
    );

    // Probe uses the captured request carried on the command bundle
    recent_line_store #(
        .recent_entries (recent_entries)
    ) u_recent (
        .clk2     (clk2),
        .reset    (reset),
        .probe    (recent_cmd.req),
        .probe_en (probe_en),
        .cmd      (recent_cmd),
        .result   (probe_result)
    );

    set_ram u_set_ram (
        .clk2       (clk2),
        .addr       (ram_index),
        .write_en   (ram_write_en),
        .write_word (ram_write_word),
        .read_word  (ram_read_word)
    );

endmodule

// ==== test/cache_lookup_checker.sv ====
`timescale 1ns/10ps

module cache_lookup_checker (
    input  logic                       clk2,
    input  logic                       reset,
    input  logic                       op_start,
    input  logic [8*24-1:0]            op_name,
    input  logic                       op_is_fill,
    input  logic                       exp_found,
    input  cache_geom_pkg::line_data_t exp_data,
    input  int                         exp_latency,
    input  logic                       final_check,
    input  logic                       lookup_done,
    input  logic                       found_in_cache,
    input  logic                       updated,
    input  cache_geom_pkg::line_data_t hit_block,
    input  cache_ctrl_pkg::hit_count_t hit_count,
    input  cache_ctrl_pkg::hit_count_t fill_count,
    output logic                       final_done,
    output int                         tests,
    output int                         failures
);
    import cache_geom_pkg::*;

    string cur_name;
    int    test_errors;
    int    cycles;
    int    exp_hits;
    int    exp_fills;
    logic  was_reset;
    logic  count_pending;

    task automatic start_test(input string name);
        cur_name    = name;
        test_errors = 0;
    endtask

    task automatic compare(input string what, input line_data_t expected,
                           input line_data_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %0s %0s: expected %0h, actual %0h",
                     cur_name, what, expected, actual);
            failures++;
            test_errors++;
        end
    endtask

    task automatic report_test();
        tests++;
        if (test_errors == 0)
            $display("%0s: ok", cur_name);
        else
            $display("%0s: failed", cur_name);
    endtask

    ////////////////////////////////////////////////////////////
    // Sampled on every rising edge
    ////////////////////////////////////////////////////////////

    always @(posedge clk2)
    begin
        if (reset)
        begin
            was_reset     = 1'b1;
            count_pending = 1'b0;
            cycles        = 0;
            exp_hits      = 0;
            exp_fills     = 0;
            tests         = 0;
            failures      = 0;
            final_done   <= 1'b0;
        end
        else
        begin
            // Cycles since the strobe
            if (op_start)
                cycles = 0;
            else
                cycles++;

            if (was_reset)
            begin
                start_test("reset_state");
                compare("lookup_done", 128'(1'b0), 128'(lookup_done));
                compare("updated", 128'(1'b0), 128'(updated));
                compare("found", 128'(1'b0), 128'(found_in_cache));
                compare("hit_count", 128'(0), 128'(hit_count));
                compare("fill_count", 128'(0), 128'(fill_count));
                report_test();
                was_reset = 1'b0;
            end

            // Counters move one edge after the pulse
            if (count_pending)
            begin
                compare("hit_count", 128'(exp_hits), 128'(hit_count));
                compare("fill_count", 128'(exp_fills), 128'(fill_count));
                report_test();
                count_pending = 1'b0;
            end

            if (lookup_done || updated)
            begin
                start_test($sformatf("%0s", op_name));
                if (op_is_fill)
                begin
                    compare("updated", 128'(1'b1), 128'(updated));
                    compare("lookup_done", 128'(1'b0), 128'(lookup_done));
                    exp_fills++;
                end
                else
                begin
                    compare("lookup_done", 128'(1'b1), 128'(lookup_done));
                    compare("found", 128'(exp_found), 128'(found_in_cache));
                    compare("hit_block", exp_data, hit_block);
                    if (exp_found)
                        exp_hits++;
                end
                compare("latency", 128'(exp_latency), 128'(cycles));
                count_pending = 1'b1;
            end

            if (final_check)
            begin
                start_test("final_counts");
                compare("hit_count", 128'(exp_hits), 128'(hit_count));
                compare("fill_count", 128'(exp_fills), 128'(fill_count));
                report_test();
                final_done <= 1'b1;
            end
        end
    end

endmodule

// ==== test/cache_lookup_tb.sv ====
`timescale 1ns/10ps

module cache_lookup_tb;
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int pulse_timeout = 10;
    localparam int op_gap        = 6;
    localparam int done_timeout  = 10;

    logic            clk2;
    logic            reset;
    logic            lookup;
    logic            fill;
    line_tag_t       tag;
    set_index_t      index;
    line_data_t      block;
    logic            lookup_done;
    logic            found_in_cache;
    logic            updated;
    line_data_t      hit_block;
    hit_count_t      hit_count;
    hit_count_t      fill_count;

    // Expected values for the checker
    logic            op_start;
    logic [8*24-1:0] op_name;
    logic            op_is_fill;
    logic            exp_found;
    line_data_t      exp_data;
    int              exp_latency;
    logic            final_check;
    logic            final_done;
    int              tests;
    int              failures;
    int              run_errors;

    cache_lookup_top #(
        .recent_entries (16)
    ) uut (
        .clk2           (clk2),
        .reset          (reset),
        .lookup         (lookup),
        .fill           (fill),
        .tag            (tag),
        .index          (index),
        .block          (block),
        .lookup_done    (lookup_done),
        .found_in_cache (found_in_cache),
        .updated        (updated),
        .hit_block      (hit_block),
        .hit_count      (hit_count),
        .fill_count     (fill_count)
    );

    cache_lookup_checker u_checker (
        .clk2           (clk2),
        .reset          (reset),
        .op_start       (op_start),
        .op_name        (op_name),
        .op_is_fill     (op_is_fill),
        .exp_found      (exp_found),
        .exp_data       (exp_data),
        .exp_latency    (exp_latency),
        .final_check    (final_check),
        .lookup_done    (lookup_done),
        .found_in_cache (found_in_cache),
        .updated        (updated),
        .hit_block      (hit_block),
        .hit_count      (hit_count),
        .fill_count     (fill_count),
        .final_done     (final_done),
        .tests          (tests),
        .failures       (failures)
    );

    initial
    begin
        clk2 = 1'b0;
        forever
        begin
            #10 clk2 = ~clk2;
        end
    end

    ////////////////////////////////////////////////////////////
    // One operation from the input file
    ////////////////////////////////////////////////////////////

    task automatic run_op(input logic [8*24-1:0] name, input logic [7:0] op,
                          input line_tag_t t, input set_index_t i, input line_data_t b,
                          input logic found, input line_data_t data, input int lat);
        int waited;
        @(posedge clk2);
        op_name     <= name;
        op_is_fill  <= (op == "F");
        exp_found   <= found;
        exp_data    <= data;
        exp_latency <= lat;
        op_start    <= 1'b1;
        tag         <= t;
        index       <= i;
        block       <= b;
        lookup      <= (op != "F");
        fill        <= (op == "F");
        @(posedge clk2);
        op_start <= 1'b0;
        lookup   <= 1'b0;
        fill     <= 1'b0;
        waited = 0;
        while (!(lookup_done || updated) && waited < pulse_timeout)
        begin
            @(posedge clk2);
            waited++;
        end
        if (waited >= pulse_timeout)
        begin
            $display("Timeout: %0s got no lookup_done or updated pulse", name);
            run_errors++;
        end
        repeat (op_gap) @(posedge clk2);
    endtask

    initial
    begin
        int               fd;
        int               n;
        int               ops;
        int               waited;
        logic [8*200-1:0] line;
        logic [8*24-1:0]  f_name;
        logic [7:0]       f_op;
        line_tag_t        f_tag;
        set_index_t       f_index;
        line_data_t       f_block;
        logic             f_found;
        line_data_t       f_data;
        int               f_lat;
        reset       = 1'b1;
        lookup      = 1'b0;
        fill        = 1'b0;
        tag         = '0;
        index       = '0;
        block       = '0;
        op_start    = 1'b0;
        op_name     = '0;
        op_is_fill  = 1'b0;
        exp_found   = 1'b0;
        exp_data    = '0;
        exp_latency = 0;
        final_check = 1'b0;
        run_errors  = 0;
        ops         = 0;
        repeat (5) @(posedge clk2);
        reset <= 1'b0;
        repeat (op_gap) @(posedge clk2);

        fd = $fopen("test/lookup_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open test/lookup_input.txt");
            run_errors++;
        end
        else
        begin
            // A line whose first token is # holds column notes
            while (!$feof(fd))
            begin
                n = $fscanf(fd, "%s", f_name);
                if (n == 1 && f_name == "#")
                begin
                    void'($fgets(line, fd));
                end
                else if (n == 1)
                begin
                    n = $fscanf(fd, "%s %h %h %h %h %h %d", f_op, f_tag, f_index,
                                f_block, f_found, f_data, f_lat);
                    if (n == 7)
                    begin
                        run_op(f_name, f_op, f_tag, f_index, f_block, f_found, f_data,
                               f_lat);
                        ops++;
                    end
                    else
                    begin
                        $display("Input line for %0s has missing or bad fields", f_name);
                        run_errors++;
                    end
                end
            end
            $fclose(fd);
        end

        if (ops == 0)
        begin
            $display("No operations were read from test/lookup_input.txt");
            run_errors++;
        end

        @(posedge clk2);
        final_check <= 1'b1;
        @(posedge clk2);
        final_check <= 1'b0;
        waited = 0;
        while (!final_done && waited < done_timeout)
        begin
            @(posedge clk2);
            waited++;
        end
        if (!final_done)
        begin
            $display("Timeout: checker did not finish the final counter check");
            run_errors++;
        end

        $display("Tests: %0d, failed checks: %0d, other failures: %0d",
                 tests, failures, run_errors);
        if (failures == 0 && run_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== test/lookup_input.txt ====
# name op tag index block found data latency
# op L looks up, F fills; tag, index, block, data in hex; latency in cycles after the strobe
cold_miss      L 00a5c 123 0 0 0 4
fill_a         F 00a5c 123 00112233445566778899aabbccddeeff 0 0 1
ram_hit_a      L 00a5c 123 0 1 00112233445566778899aabbccddeeff 4
recent_hit_a   L 00a5c 123 0 1 00112233445566778899aabbccddeeff 2
fill_b         F 1b3e7 123 f0e1d2c3b4a5968778695a4b3c2d1e0f 0 0 1
old_tag_miss   L 00a5c 123 0 0 0 4
ram_hit_b      L 1b3e7 123 0 1 f0e1d2c3b4a5968778695a4b3c2d1e0f 4
recent_hit_b   L 1b3e7 123 0 1 f0e1d2c3b4a5968778695a4b3c2d1e0f 2
fill_c         F 04411 7ff 13579bdf02468ace13579bdf02468ace 0 0 1
ram_hit_c      L 04411 7ff 0 1 13579bdf02468ace13579bdf02468ace 4
tag_miss_c     L 04412 7ff 0 0 0 4
recent_hit_c   L 04411 7ff 0 1 13579bdf02468ace13579bdf02468ace 2
still_hit_b    L 1b3e7 123 0 1 f0e1d2c3b4a5968778695a4b3c2d1e0f 2

// ==== build.f ====
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/recent_line_store.sv
logic/set_ram.sv
logic/lookup_control.sv
logic/cache_lookup_top.sv
test/cache_lookup_checker.sv
test/cache_lookup_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps
TOP       = cache_lookup_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
